//--- design/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_EQ
    } alu_op_t;

    typedef enum logic [3:0] {
        ST_LOAD,
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_WRITEBACK,
        ST_PRINT_ADDR,
        ST_PRINT_COUNT,
        ST_PRINT_SEND,
        ST_HALTED
    } cpu_state_t;

    // one decoded instruction, registered by the sequencer
    typedef struct packed {
        alu_op_t   alu_op;
        logic      a_shamt;
        logic      b_imm;
        logic      zero_ext;
        logic      reg_write;
        reg_addr_t dest;
        logic      mem_read;
        logic      mem_write;
        logic      branch_eq;
        logic      branch_ne;
        logic      jump;
        logic      jump_link;
        logic      jump_reg;
    } decoded_t;

    localparam word_t     RESET_PC = 32'h0040_0000;
    localparam word_t     SP_INIT  = 32'h7fff_effc;
    localparam reg_addr_t CTRL_REG = 5'd27;
    localparam reg_addr_t SP_REG   = 5'd29;
    localparam reg_addr_t LINK_REG = 5'd31;

    localparam int unsigned CTRL_PRINT_BIT = 1;
    localparam int unsigned CTRL_HALT_BIT  = 3;

    localparam int unsigned IMEM_WORDS = 1024;
    localparam int unsigned DMEM_WORDS = 16384;

    // primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_SLTIU = 6'h0b;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // function codes for the R-type group
    localparam funct_t F_SLL  = 6'h00;
    localparam funct_t F_SRL  = 6'h02;
    localparam funct_t F_SRA  = 6'h03;
    localparam funct_t F_SLLV = 6'h04;
    localparam funct_t F_SRLV = 6'h06;
    localparam funct_t F_SRAV = 6'h07;
    localparam funct_t F_JR   = 6'h08;
    localparam funct_t F_ADDU = 6'h21;
    localparam funct_t F_SUBU = 6'h23;
    localparam funct_t F_AND  = 6'h24;
    localparam funct_t F_OR   = 6'h25;
    localparam funct_t F_XOR  = 6'h26;
    localparam funct_t F_NOR  = 6'h27;
    localparam funct_t F_SLT  = 6'h2a;
    localparam funct_t F_SLTU = 6'h2b;

endpackage

//--- design/word_memory.sv
`timescale 1ns/1ns

module word_memory import cpu_pkg::*; #(
    parameter int unsigned depth = 1024
) (
    input  logic  clk,
    input  word_t addr,
    input  word_t wdata,
    input  logic  we,
    output word_t rdata
);

    localparam int unsigned aw = $clog2(depth);

    word_t mem [depth];

    // byte address, low two bits dropped; upper bits alias
    logic [aw-1:0] index;

    assign index = addr[aw+1:2];
    assign rdata = mem[index];

    always_ff @(posedge clk) begin
        if (we)
            mem[index] <= wdata;
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t wr_addr,
    input  logic      wr_en,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data,
    output word_t     ctrl_value
);

    word_t regs [32];

    assign rs_data    = regs[rs_addr];
    assign rt_data    = regs[rt_addr];
    assign ctrl_value = regs[CTRL_REG];

    always_ff @(posedge clk) begin
        if (reset) begin
            // stack pointer starts below the top of data memory
            for (int i = 0; i < 32; i++)
                regs[i] <= (reg_addr_t'(i) == SP_REG) ? SP_INIT : '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

//--- design/alu.sv
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shift amount comes from a, either shamt field or rs
    assign shamt       = a[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_NOR:  y = ~(a | b);
            ALU_SLT:  y = {31'b0, lt_signed};
            ALU_SLTU: y = {31'b0, lt_unsigned};
            ALU_SLL:  y = b << shamt;
            ALU_SRL:  y = b >> shamt;
            ALU_SRA:  y = $signed(b) >>> shamt;
            ALU_LUI:  y = {b[15:0], 16'b0};
            // branch compare, flag in bit 0
            ALU_EQ:   y = {31'b0, a == b};
            default:  y = '0;
        endcase
    end

endmodule

//--- design/instr_decode.sv
`timescale 1ns/1ns

module instr_decode import cpu_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    opcode_t op;
    funct_t  fn;

    assign op = instr[31:26];
    assign fn = instr[5:0];

    always_comb begin
        dec        = '0;
        dec.alu_op = ALU_ADD;
        // I-type results go to rt
        dec.dest   = instr[20:16];
        case (op)
            OP_RTYPE: begin
                dec.dest      = instr[15:11];
                dec.reg_write = 1'b1;
                dec.a_shamt   = (fn == F_SLL) || (fn == F_SRL) || (fn == F_SRA);
                case (fn)
                    F_ADDU:             dec.alu_op = ALU_ADD;
                    F_SUBU:             dec.alu_op = ALU_SUB;
                    F_AND:              dec.alu_op = ALU_AND;
                    F_OR:               dec.alu_op = ALU_OR;
                    F_XOR:              dec.alu_op = ALU_XOR;
                    F_NOR:              dec.alu_op = ALU_NOR;
                    F_SLT:              dec.alu_op = ALU_SLT;
                    F_SLTU:             dec.alu_op = ALU_SLTU;
                    F_SLL, F_SLLV:      dec.alu_op = ALU_SLL;
                    F_SRL, F_SRLV:      dec.alu_op = ALU_SRL;
                    F_SRA, F_SRAV:      dec.alu_op = ALU_SRA;
                    F_JR: begin
                        dec.reg_write = 1'b0;
                        dec.jump_reg  = 1'b1;
                    end
                    default:            dec.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.reg_write = 1'b1;
                dec.b_imm     = 1'b1;
                dec.zero_ext  = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
                case (op)
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    OP_SLTIU: dec.alu_op = ALU_SLTU;
                    OP_ANDI:  dec.alu_op = ALU_AND;
                    OP_ORI:   dec.alu_op = ALU_OR;
                    OP_XORI:  dec.alu_op = ALU_XOR;
                    OP_LUI:   dec.alu_op = ALU_LUI;
                    default:  dec.alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                dec.b_imm     = 1'b1;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_SW: begin
                dec.b_imm     = 1'b1;
                dec.mem_write = 1'b1;
            end
            OP_BEQ: begin
                dec.alu_op    = ALU_EQ;
                dec.branch_eq = 1'b1;
            end
            OP_BNE: begin
                dec.alu_op    = ALU_EQ;
                dec.branch_ne = 1'b1;
            end
            OP_J:    dec.jump = 1'b1;
            OP_JAL: begin
                dec.jump      = 1'b1;
                dec.jump_link = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest      = LINK_REG;
            end
            default: dec.reg_write = 1'b0;
        endcase
    end

endmodule

//--- design/control_fsm.sv
`timescale 1ns/1ns

module control_fsm import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  word_t     in_data,
    output logic      in_ready,
    output logic      out_valid,
    output word_t     out_data,
    input  logic      out_ready,
    output logic      halted,
    input  word_t     instr,
    output word_t     imem_addr,
    output word_t     imem_wdata,
    output logic      imem_we,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_we,
    input  word_t     dmem_rdata,
    input  decoded_t  dec,
    output alu_op_t   alu_op,
    output word_t     alu_a,
    output word_t     alu_b,
    input  word_t     alu_y,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output reg_addr_t wr_addr,
    input  word_t     rs_data,
    input  word_t     rt_data,
    input  word_t     ctrl_value,
    output logic      wr_en,
    output word_t     wr_data
);

    cpu_state_t state;
    word_t      pc;
    word_t      ir;
    decoded_t   dec_q;
    word_t      alu_q;
    word_t      stream_addr;
    word_t      remaining;
    word_t      imm_ext;
    word_t      branch_offset;
    logic       printing;
    logic       take_branch;

    assign printing = (state == ST_PRINT_ADDR) || (state == ST_PRINT_COUNT) ||
                      (state == ST_PRINT_SEND);

    // loader and streamer share one address counter
    assign in_ready   = (state == ST_LOAD);
    assign imem_addr  = (state == ST_LOAD) ? stream_addr : pc;
    assign imem_wdata = in_data;
    assign imem_we    = in_ready && in_valid;
    assign halted     = (state == ST_HALTED);

    assign imm_ext = dec_q.zero_ext ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign branch_offset = {{14{ir[15]}}, ir[15:0], 2'b00};
    assign take_branch = (dec_q.branch_eq && alu_q[0]) || (dec_q.branch_ne && !alu_q[0]);

    assign rs_addr = printing ? SP_REG : ir[25:21];
    assign rt_addr = ir[20:16];
    assign alu_op  = dec_q.alu_op;
    assign alu_a   = dec_q.a_shamt ? {27'b0, ir[10:6]} : rs_data;
    assign alu_b   = dec_q.b_imm ? imm_ext : rt_data;

    assign dmem_addr  = printing ? stream_addr : alu_q;
    assign dmem_wdata = rt_data;
    assign dmem_we    = (state == ST_WRITEBACK) && dec_q.mem_write;

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = dec_q.dest;
        wr_data = alu_q;
        if (state == ST_FETCH) begin
            // clear the print request as it is taken
            wr_addr = CTRL_REG;
            wr_data = ctrl_value & ~(word_t'(1) << CTRL_PRINT_BIT);
            wr_en   = !ctrl_value[CTRL_HALT_BIT] && ctrl_value[CTRL_PRINT_BIT];
        end else if (state == ST_WRITEBACK) begin
            wr_en = dec_q.reg_write;
            if (dec_q.jump_link)
                wr_data = pc;
            else if (dec_q.mem_read)
                wr_data = dmem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_LOAD;
            pc          <= RESET_PC;
            stream_addr <= RESET_PC;
            out_valid   <= 1'b0;
        end else begin
            case (state)
                ST_LOAD: begin
                    if (in_valid) begin
                        stream_addr <= stream_addr + 32'd4;
                        if (in_data == '0)
                            state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    ir <= instr;
                    if (ctrl_value[CTRL_HALT_BIT])
                        state <= ST_HALTED;
                    else if (ctrl_value[CTRL_PRINT_BIT])
                        state <= ST_PRINT_ADDR;
                    else
                        state <= ST_DECODE;
                end
                ST_DECODE: begin
                    dec_q <= dec;
                    pc    <= pc + 32'd4;
                    state <= ST_EXEC;
                end
                ST_EXEC: begin
                    alu_q <= alu_y;
                    state <= ST_WRITEBACK;
                end
                ST_WRITEBACK: begin
                    if (dec_q.jump_reg)
                        pc <= rs_data;
                    else if (dec_q.jump)
                        pc <= {pc[31:28], ir[25:0], 2'b00};
                    else if (take_branch)
                        pc <= pc + branch_offset;
                    state <= ST_FETCH;
                end
                ST_PRINT_ADDR: begin
                    stream_addr <= rs_data;
                    state       <= ST_PRINT_COUNT;
                end
                ST_PRINT_COUNT: begin
                    remaining   <= dmem_rdata;
                    stream_addr <= stream_addr + 32'd4;
                    state       <= ST_PRINT_SEND;
                end
                ST_PRINT_SEND: begin
                    // word held until it transfers, then the next one loads
                    if (!out_valid || out_ready) begin
                        if (remaining == '0) begin
                            out_valid <= 1'b0;
                            state     <= ST_FETCH;
                        end else begin
                            out_data    <= dmem_rdata;
                            out_valid   <= 1'b1;
                            stream_addr <= stream_addr + 32'd4;
                            remaining   <= remaining - 32'd1;
                        end
                    end
                end
                default: state <= ST_HALTED;
            endcase
        end
    end

endmodule

//--- design/cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    input  word_t in_data,
    output logic  in_ready,
    output logic  out_valid,
    output word_t out_data,
    input  logic  out_ready,
    output logic  halted
);

    word_t     instr;
    word_t     imem_addr;
    word_t     imem_wdata;
    logic      imem_we;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    word_t     dmem_rdata;
    logic      dmem_we;
    decoded_t  dec;
    alu_op_t   alu_op;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_y;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t wr_addr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     ctrl_value;
    logic      wr_en;
    word_t     wr_data;

    control_fsm u_control (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
        .halted(halted),
        .instr(instr), .imem_addr(imem_addr), .imem_wdata(imem_wdata), .imem_we(imem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata),
        .dec(dec), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_y(alu_y),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .wr_addr(wr_addr),
        .rs_data(rs_data), .rt_data(rt_data), .ctrl_value(ctrl_value),
        .wr_en(wr_en), .wr_data(wr_data)
    );

    // decodes the word at pc, which the sequencer holds steady through decode
    instr_decode u_decode (.instr(instr), .dec(dec));

    alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .wr_addr(wr_addr),
        .wr_en(wr_en), .wr_data(wr_data),
        .rs_data(rs_data), .rt_data(rt_data), .ctrl_value(ctrl_value)
    );

    word_memory #(.depth(IMEM_WORDS)) imem (
        .clk(clk), .addr(imem_addr), .wdata(imem_wdata), .we(imem_we), .rdata(instr)
    );

    word_memory #(.depth(DMEM_WORDS)) dmem (
        .clk(clk), .addr(dmem_addr), .wdata(dmem_wdata), .we(dmem_we), .rdata(dmem_rdata)
    );

endmodule

//--- tests/cpu_properties.sv
`timescale 1ns/1ns

module cpu_properties import cpu_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  in_ready,
    input logic  out_valid,
    input word_t out_data,
    input logic  out_ready,
    input logic  halted
);

    // a stalled output word stays put until the sink takes it
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("output word changed while out_ready was low");

    // only reset leaves the halted state
    assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else $error("halted fell without reset");

    // loader and streamer never run at once
    assert property (@(posedge clk) disable iff (reset)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid high together");

endmodule

bind cpu_top cpu_properties u_properties (
    .clk(clk), .reset(reset), .in_ready(in_ready), .out_valid(out_valid),
    .out_data(out_data), .out_ready(out_ready), .halted(halted)
);

//--- tests/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// ISA model: runs program_words from RESET_PC, one instruction per step,
// and appends every word a print request sends to expected_words
task automatic model_run();
    word_t       regs [32];
    word_t       dmem [word_t];
    word_t       pc;
    word_t       next_pc;
    word_t       ins;
    word_t       a;
    word_t       b;
    word_t       simm;
    word_t       value;
    word_t       count;
    reg_addr_t   dest;
    logic        write;
    int unsigned steps;
    expected_words = {};
    for (int i = 0; i < 32; i++)
        regs[i] = '0;
    regs[SP_REG] = SP_INIT;
    pc = RESET_PC;
    steps = 0;
    while (!regs[CTRL_REG][CTRL_HALT_BIT] && steps < 10000) begin
        steps++;
        if (regs[CTRL_REG][CTRL_PRINT_BIT]) begin
            // count word at sp, data words right above it
            regs[CTRL_REG][CTRL_PRINT_BIT] = 1'b0;
            count = dmem[regs[SP_REG]];
            for (word_t k = 1; k <= count; k++)
                expected_words.push_back(dmem[regs[SP_REG] + 4 * k]);
        end else begin
            ins = program_words[(pc - RESET_PC) >> 2];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            next_pc = pc + 32'd4;
            write = 1'b1;
            dest = ins[20:16];
            value = '0;
            case (ins[31:26])
                OP_RTYPE: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        F_ADDU:  value = a + b;
                        F_SUBU:  value = a - b;
                        F_AND:   value = a & b;
                        F_OR:    value = a | b;
                        F_XOR:   value = a ^ b;
                        F_NOR:   value = ~(a | b);
                        F_SLT:   value = {31'b0, $signed(a) < $signed(b)};
                        F_SLTU:  value = {31'b0, a < b};
                        F_SLL:   value = b << ins[10:6];
                        F_SRL:   value = b >> ins[10:6];
                        F_SRA:   value = $signed(b) >>> ins[10:6];
                        F_SLLV:  value = b << a[4:0];
                        F_SRLV:  value = b >> a[4:0];
                        F_SRAV:  value = $signed(b) >>> a[4:0];
                        F_JR: begin
                            write = 1'b0;
                            next_pc = a;
                        end
                        default: write = 1'b0;
                    endcase
                end
                OP_ADDIU: value = a + simm;
                OP_SLTI:  value = {31'b0, $signed(a) < $signed(simm)};
                OP_SLTIU: value = {31'b0, a < simm};
                OP_ANDI:  value = a & {16'h0, ins[15:0]};
                OP_ORI:   value = a | {16'h0, ins[15:0]};
                OP_XORI:  value = a ^ {16'h0, ins[15:0]};
                OP_LUI:   value = {ins[15:0], 16'h0};
                OP_LW:    value = dmem[a + simm];
                OP_SW: begin
                    write = 1'b0;
                    dmem[a + simm] = b;
                end
                OP_BEQ, OP_BNE: begin
                    write = 1'b0;
                    if ((a == b) == (ins[31:26] == OP_BEQ))
                        next_pc = next_pc + (simm << 2);
                end
                OP_J, OP_JAL: begin
                    write = (ins[31:26] == OP_JAL);
                    dest = LINK_REG;
                    value = next_pc;
                    next_pc = {next_pc[31:28], ins[25:0], 2'b00};
                end
                default: write = 1'b0;
            endcase
            if (write && dest != 5'd0)
                regs[dest] = value;
            pc = next_pc;
        end
    end
endtask

`endif

//--- tests/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

    logic  clk;
    logic  reset = 1'b1;
    logic  in_valid = 1'b0;
    word_t in_data = '0;
    logic  in_ready;
    logic  out_valid;
    word_t out_data;
    logic  out_ready = 1'b0;
    logic  halted;

    word_t       program_words[$];
    word_t       expected_words[$];
    word_t       received_words[$];
    logic [7:0]  slots_written;
    word_t       gen_state = 32'd12;
    word_t       ready_state = 32'd12;
    int unsigned error_count;
    int unsigned tests_run;
    int unsigned tests_passed;
    int unsigned cycle_count = 0;
    int unsigned test_start = 0;
    int unsigned cycle_limit = 1000;

    cpu_top UUT (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
        .halted(halted)
    );

    `include "cpu_model.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // per-test cycle limit from program length and print size
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count - test_start > cycle_limit) begin
            $display("timeout: test %0d did not halt within %0d cycles", tests_run, cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // random back-pressure on the output stream
    always @(posedge clk) begin
        ready_state = lcg(ready_state);
        out_ready <= ready_state[20];
    end

    function automatic word_t lcg(input word_t s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        gen_state = lcg(gen_state);
        return (gen_state >> 8) % n;
    endfunction

    function automatic reg_addr_t pick_reg();
        return reg_addr_t'(1 + rand_below(25));
    endfunction

    function automatic word_t alu_instr();
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        opcode_t     op;
        funct_t      fn;
        rs = pick_reg();
        rt = pick_reg();
        rd = pick_reg();
        sh = 5'(rand_below(32));
        imm = 16'(rand_below(65536));
        op = OP_RTYPE;
        fn = F_ADDU;
        case (rand_below(21))
            1:  fn = F_SUBU;
            2:  fn = F_AND;
            3:  fn = F_OR;
            4:  fn = F_XOR;
            5:  fn = F_NOR;
            6:  fn = F_SLT;
            7:  fn = F_SLTU;
            8:  fn = F_SLL;
            9:  fn = F_SRL;
            10: fn = F_SRA;
            11: fn = F_SLLV;
            12: fn = F_SRLV;
            13: fn = F_SRAV;
            14: op = OP_ADDIU;
            15: op = OP_SLTI;
            16: op = OP_SLTIU;
            17: op = OP_ANDI;
            18: op = OP_ORI;
            19: op = OP_XORI;
            20: op = OP_LUI;
            default: fn = F_ADDU;
        endcase
        if (op == OP_RTYPE)
            return {op, rs, rt, rd, sh, fn};
        return {op, rs, rt, imm};
    endfunction

    // sw to a scratch slot below sp, or lw from one already written
    function automatic word_t mem_instr();
        logic [2:0] slot;
        word_t      offset;
        slot = 3'(rand_below(8));
        offset = 32'd0 - ((32'(slot) + 32'd1) << 2);
        if (slots_written[slot] && rand_below(2) == 0)
            return {OP_LW, SP_REG, pick_reg(), offset[15:0]};
        slots_written[slot] = 1'b1;
        return {OP_SW, SP_REG, pick_reg(), offset[15:0]};
    endfunction

    task automatic build_program(input int unsigned body_len);
        int unsigned skip;
        int unsigned count;
        opcode_t     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        word_t       target;
        program_words = {};
        slots_written = '0;
        // straight-line part is the only one with memory traffic
        for (int unsigned i = 0; i < body_len; i++) begin
            if (rand_below(4) == 0)
                program_words.push_back(mem_instr());
            else
                program_words.push_back(alu_instr());
        end
        skip = 1 + rand_below(3);
        op = (rand_below(2) == 0) ? OP_BEQ : OP_BNE;
        rs = pick_reg();
        rt = (rand_below(2) == 0) ? rs : pick_reg();
        program_words.push_back({op, rs, rt, 16'(skip)});
        repeat (skip) program_words.push_back(alu_instr());
        skip = 1 + rand_below(3);
        target = RESET_PC + 4 * (program_words.size() + 1 + skip);
        program_words.push_back({OP_J, target[27:2]});
        repeat (skip + 3) program_words.push_back(alu_instr());
        // printed registers go above sp and the count goes at sp
        count = 2 + rand_below(6);
        for (int unsigned k = 1; k <= count; k++)
            program_words.push_back({OP_SW, SP_REG, pick_reg(), 16'(4 * k)});
        program_words.push_back({OP_ADDIU, 5'd0, 5'd26, 16'(count)});
        program_words.push_back({OP_SW, SP_REG, 5'd26, 16'd0});
        program_words.push_back({OP_ORI, CTRL_REG, CTRL_REG, 16'h0002});
        program_words.push_back({OP_ORI, CTRL_REG, CTRL_REG, 16'h0008});
        program_words.push_back(32'h0);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset    <= 1'b1;
        in_valid <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic load_program();
        foreach (program_words[i]) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= program_words[i];
            // word transfers on the edge after in_ready is seen
            do
                @(negedge clk);
            while (!in_ready);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_value("in_ready", {31'b0, in_ready}, 32'd0);
    endtask

    task automatic run_test(input int unsigned body_len);
        int unsigned errors_before;
        errors_before = error_count;
        tests_run++;
        build_program(body_len);
        model_run();
        received_words = {};
        test_start = cycle_count;
        cycle_limit = 4 * program_words.size() + expected_words.size() + 300;
        apply_reset();
        @(negedge clk);
        check_value("in_ready", {31'b0, in_ready}, 32'd1);
        check_value("out_valid", {31'b0, out_valid}, 32'd0);
        check_value("halted", {31'b0, halted}, 32'd0);
        load_program();
        while (!halted) begin
            @(negedge clk);
            if (out_valid && out_ready)
                received_words.push_back(out_data);
        end
        // halted holds with the stream quiet
        repeat (12) begin
            @(negedge clk);
            check_value("halted", {31'b0, halted}, 32'd1);
            check_value("out_valid", {31'b0, out_valid}, 32'd0);
        end
        check_value("output word count", word_t'(received_words.size()),
                    word_t'(expected_words.size()));
        foreach (expected_words[i]) begin
            if (i < received_words.size())
                check_value($sformatf("out_data[%0d]", i), received_words[i], expected_words[i]);
        end
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %0d: %0d words loaded, %0d printed, ok",
                     tests_run, program_words.size(), received_words.size());
        end else begin
            $display("test %0d: %0d words loaded, %0d printed, mismatch",
                     tests_run, program_words.size(), received_words.size());
        end
    endtask

    initial begin
        error_count = 0;
        tests_run = 0;
        tests_passed = 0;
        run_test(10);
        run_test(20);
        run_test(35);
        run_test(60);
        $display("%0d of %0d tests passed, %0d mismatches", tests_passed, tests_run, error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- project.f
+incdir+tests
design/cpu_pkg.sv
design/word_memory.sv
design/reg_file.sv
design/alu.sv
design/instr_decode.sv
design/control_fsm.sv
design/cpu_top.sv
tests/cpu_properties.sv
tests/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build the RTL and testbench with Verilator, then run the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f project.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
